// File: alu_exec.sv
// =========================================================================
// ALU, execute register, writeback and retire outputs
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module alu_exec (
  input  logic                            clk,
  input  logic                            rst_n_i,
  issue_if.dst                            issue,
  wb_if.src                               wb,
  output logic                            retire_valid_o,
  output logic                            retire_we_o,
  output logic [pipe_cfg_pkg::REG_AW-1:0] retire_rd_o,
  output logic [pipe_cfg_pkg::XLEN-1:0]   retire_data_o
);

  logic [pipe_cfg_pkg::XLEN-1:0]   result;
  logic                            known;
  logic                            we;

  // execute register
  logic                            valid_q;
  logic                            we_q;
  logic [pipe_cfg_pkg::REG_AW-1:0] rd_q;
  logic [pipe_cfg_pkg::XLEN-1:0]   data_q;

  // ================================ ALU ==================================
  // I-forms arrive with the immediate already in src1
  always_comb begin
    known  = 1'b1;
    result = '0;
    case (issue.op)
      isa_pkg::OP_ADD,
      isa_pkg::OP_ADDI: result = issue.src0 + issue.src1;
      isa_pkg::OP_SUB:  result = issue.src0 - issue.src1;
      isa_pkg::OP_AND:  result = issue.src0 & issue.src1;
      isa_pkg::OP_OR,
      isa_pkg::OP_ORI:  result = issue.src0 | issue.src1;
      isa_pkg::OP_XOR:  result = issue.src0 ^ issue.src1;
      isa_pkg::OP_SLT: begin
        result = {{(pipe_cfg_pkg::XLEN - 1){1'b0}},
                  ($signed(issue.src0) < $signed(issue.src1))};
      end
      default:          known = 1'b0;
    endcase
  end

  // no-ops and writes to r0 retire without a write
  assign we = issue.valid && known && (issue.rd != '0);

  // ========================== execute register ===========================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      valid_q <= issue.valid;
      we_q    <= we;
    end
  end

  always_ff @(posedge clk) begin
    rd_q   <= issue.rd;
    data_q <= result;
  end

  // writeback and bypass
  assign wb.valid = valid_q;
  assign wb.we    = we_q;
  assign wb.rd    = rd_q;
  assign wb.data  = data_q;

  // retire report
  assign retire_valid_o = valid_q;
  assign retire_we_o    = we_q;
  assign retire_rd_o    = rd_q;
  assign retire_data_o  = data_q;

endmodule : alu_exec

`default_nettype wire

// File: decode_stage.sv
// =========================================================================
// instruction decode, operand read with bypass, decode register
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          head_valid_i,
  input  logic [pipe_cfg_pkg::XLEN-1:0] head_word_i,
  output logic                          pop_o,
  rf_read_if.req                        rf,
  wb_if.dst                             wb,
  issue_if.src                          issue
);

  isa_pkg::inst_u                  inst;
  logic                            is_imm;
  logic [pipe_cfg_pkg::REG_AW-1:0] rs1;
  logic [pipe_cfg_pkg::REG_AW-1:0] rs2;
  logic [pipe_cfg_pkg::XLEN-1:0]   opnd0;
  logic [pipe_cfg_pkg::XLEN-1:0]   opnd1;
  logic                            fwd0;
  logic                            fwd1;

  // decode register
  logic                            valid_q;
  logic [isa_pkg::OP_W-1:0]        op_q;
  logic [pipe_cfg_pkg::REG_AW-1:0] rd_q;
  logic [pipe_cfg_pkg::XLEN-1:0]   src0_q;
  logic [pipe_cfg_pkg::XLEN-1:0]   src1_q;
  logic                            fwd0_q;
  logic                            fwd1_q;

  // no stalls downstream, so the head is always consumed
  assign pop_o = head_valid_i;
  assign inst  = head_word_i;

  // ============================ field decode =============================
  assign is_imm = (inst.i.opcode == isa_pkg::OP_ADDI) || (inst.i.opcode == isa_pkg::OP_ORI);
  assign rs1    = inst.i.rs1;
  // I-form has no second register source
  assign rs2    = is_imm ? '0 : inst.r.rs2;

  assign rf.raddr0 = rs1;
  assign rf.raddr1 = rs2;

  // ========================== operand bypass =============================
  // execute register result is not yet in the register file
  always_comb begin
    opnd0 = rf.rdata0;
    opnd1 = rf.rdata1;
    if (wb.we && (wb.rd == rs1) && (rs1 != '0)) begin
      opnd0 = wb.data;
    end
    if (wb.we && (wb.rd == rs2) && (rs2 != '0)) begin
      opnd1 = wb.data;
    end
    if (is_imm) begin
      opnd1 = {{(pipe_cfg_pkg::XLEN - isa_pkg::IMM_W){1'b0}}, inst.i.imm};
    end
  end

  // source written by the instruction one slot ahead, result not ready yet
  assign fwd0 = valid_q && (rd_q == rs1) && (rs1 != '0);
  assign fwd1 = valid_q && (rd_q == rs2) && (rs2 != '0);

  // ========================== decode register ============================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      fwd0_q  <= 1'b0;
      fwd1_q  <= 1'b0;
    end else begin
      valid_q <= head_valid_i;
      fwd0_q  <= head_valid_i && fwd0;
      fwd1_q  <= head_valid_i && fwd1;
    end
  end

  always_ff @(posedge clk) begin
    op_q   <= inst.r.opcode;
    rd_q   <= inst.r.rd;
    src0_q <= opnd0;
    src1_q <= opnd1;
  end

  // that older instruction now sits in the execute register
  assign issue.valid = valid_q;
  assign issue.op    = op_q;
  assign issue.rd    = rd_q;
  assign issue.src0  = (fwd0_q && wb.we) ? wb.data : src0_q;
  assign issue.src1  = (fwd1_q && wb.we) ? wb.data : src1_q;

endmodule : decode_stage

`default_nettype wire

// File: inst_buffer.sv
// =========================================================================
// instruction FIFO between the input port and decode
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module inst_buffer (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          push_valid_i,
  input  logic [pipe_cfg_pkg::XLEN-1:0] push_word_i,
  output logic                          push_ready_o,
  output logic                          head_valid_o,
  output logic [pipe_cfg_pkg::XLEN-1:0] head_word_o,
  input  logic                          pop_i
);

  logic [pipe_cfg_pkg::XLEN-1:0]    mem_q [pipe_cfg_pkg::IBUF_DEPTH];
  logic [pipe_cfg_pkg::IBUF_AW-1:0] wr_ptr_q;
  logic [pipe_cfg_pkg::IBUF_AW-1:0] rd_ptr_q;
  logic [pipe_cfg_pkg::IBUF_AW:0]   count_q;
  logic                             push;
  logic                             pop;

  // only back-pressure point of the pipeline
  assign push_ready_o = (count_q != (pipe_cfg_pkg::IBUF_AW + 1)'(pipe_cfg_pkg::IBUF_DEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_word_o  = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_i & head_valid_o;

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_word_i;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // occupancy, push and pop together leave it unchanged
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule : inst_buffer

`default_nettype wire

// File: isa_pkg.sv
// =========================================================================
// opcode encodings, immediate width and the instruction word union
// =========================================================================

`default_nettype none

package isa_pkg;

  localparam int OP_W = 4;

  // register-register forms
  localparam logic [OP_W-1:0] OP_ADD  = 4'h1;
  localparam logic [OP_W-1:0] OP_SUB  = 4'h2;
  localparam logic [OP_W-1:0] OP_AND  = 4'h3;
  localparam logic [OP_W-1:0] OP_OR   = 4'h4;
  localparam logic [OP_W-1:0] OP_XOR  = 4'h5;
  localparam logic [OP_W-1:0] OP_SLT  = 4'h6;

  // register-immediate forms
  localparam logic [OP_W-1:0] OP_ADDI = 4'h8;
  localparam logic [OP_W-1:0] OP_ORI  = 4'h9;

  // any other opcode retires as a no-op

  localparam int IMM_W = 18;

  // one 32-bit word, opcode always in the top nibble
  // r view  : opcode | rd | rs1 | rs2 | unused
  // i view  : opcode | rd | rs1 | imm
  typedef union packed {
    struct packed {
      logic [OP_W-1:0]                          opcode;
      logic [pipe_cfg_pkg::REG_AW-1:0]          rd;
      logic [pipe_cfg_pkg::REG_AW-1:0]          rs1;
      logic [pipe_cfg_pkg::REG_AW-1:0]          rs2;
      logic [IMM_W-pipe_cfg_pkg::REG_AW-1:0]    unused;
    } r;
    struct packed {
      logic [OP_W-1:0]                          opcode;
      logic [pipe_cfg_pkg::REG_AW-1:0]          rd;
      logic [pipe_cfg_pkg::REG_AW-1:0]          rs1;
      logic [IMM_W-1:0]                         imm;
    } i;
  } inst_u;

endpackage : isa_pkg

`default_nettype wire

// File: pipe_cfg_pkg.sv
// =========================================================================
// sizing constants for the data path, the register file
// and the instruction buffer
// =========================================================================

`default_nettype none

package pipe_cfg_pkg;

  // data path width
  localparam int XLEN = 32;

  // architectural registers
  localparam int REG_NUM = 32;
  localparam int REG_AW  = 5;

  // instruction buffer, one word per entry
  localparam int IBUF_DEPTH = 8;
  localparam int IBUF_AW    = 3;

endpackage : pipe_cfg_pkg

`default_nettype wire

// File: pipe_ifs.sv
// =========================================================================
// register file read, issue and writeback interfaces
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

// two combinational read ports, addresses out and data back
interface rf_read_if;

  logic [pipe_cfg_pkg::REG_AW-1:0] raddr0;
  logic [pipe_cfg_pkg::REG_AW-1:0] raddr1;
  logic [pipe_cfg_pkg::XLEN-1:0]   rdata0;
  logic [pipe_cfg_pkg::XLEN-1:0]   rdata1;

  modport req (output raddr0, output raddr1, input rdata0, input rdata1);
  modport rsp (input raddr0, input raddr1, output rdata0, output rdata1);

endinterface : rf_read_if

// decode to execute, operands already resolved
interface issue_if;

  logic                            valid;
  logic [isa_pkg::OP_W-1:0]        op;
  logic [pipe_cfg_pkg::REG_AW-1:0] rd;
  logic [pipe_cfg_pkg::XLEN-1:0]   src0;
  logic [pipe_cfg_pkg::XLEN-1:0]   src1;

  modport src (output valid, output op, output rd, output src0, output src1);
  modport dst (input valid, input op, input rd, input src0, input src1);

endinterface : issue_if

// execute result, also the bypass source for decode
interface wb_if;

  logic                            valid;
  logic                            we;
  logic [pipe_cfg_pkg::REG_AW-1:0] rd;
  logic [pipe_cfg_pkg::XLEN-1:0]   data;

  modport src (output valid, output we, output rd, output data);
  modport dst (input valid, input we, input rd, input data);

endinterface : wb_if

`default_nettype wire

// File: pipeline.f
pipe_cfg_pkg.sv
isa_pkg.sv
pipe_ifs.sv
inst_buffer.sv
decode_stage.sv
reg_file.sv
alu_exec.sv
pipeline_top.sv
tb_pipeline.sv

// File: pipeline_top.sv
// =========================================================================
// pipeline top level, buffer to decode to execute
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module pipeline_top (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            inst_valid_i,
  input  logic [pipe_cfg_pkg::XLEN-1:0]   inst_word_i,
  output logic                            inst_ready_o,
  output logic                            retire_valid_o,
  output logic                            retire_we_o,
  output logic [pipe_cfg_pkg::REG_AW-1:0] retire_rd_o,
  output logic [pipe_cfg_pkg::XLEN-1:0]   retire_data_o
);

  // buffer head to decode
  logic                          head_valid;
  logic [pipe_cfg_pkg::XLEN-1:0] head_word;
  logic                          pop;

  rf_read_if u_rf_if ();
  issue_if   u_issue_if ();
  wb_if      u_wb_if ();

  // ========================= instruction buffer ==========================
  inst_buffer u_inst_buffer (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_valid_i (inst_valid_i),
    .push_word_i  (inst_word_i),
    .push_ready_o (inst_ready_o),
    .head_valid_o (head_valid),
    .head_word_o  (head_word),
    .pop_i        (pop)
  );

  // =============================== decode ================================
  decode_stage u_decode_stage (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .head_valid_i (head_valid),
    .head_word_i  (head_word),
    .pop_o        (pop),
    .rf           (u_rf_if),
    .wb           (u_wb_if),
    .issue        (u_issue_if)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .rf      (u_rf_if),
    .wb      (u_wb_if)
  );

  // ============================== execute ================================
  alu_exec u_alu_exec (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .issue          (u_issue_if),
    .wb             (u_wb_if),
    .retire_valid_o (retire_valid_o),
    .retire_we_o    (retire_we_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

endmodule : pipeline_top

`default_nettype wire

// File: reg_file.sv
// =========================================================================
// 32-entry register file, two read ports and one write port
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic clk,
  input  logic rst_n_i,
  rf_read_if.rsp rf,
  wb_if.dst      wb
);

  logic [pipe_cfg_pkg::XLEN-1:0] regs_q [pipe_cfg_pkg::REG_NUM];

  // write lands one edge after the execute register
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int n = 0; n < pipe_cfg_pkg::REG_NUM; n++) begin
        regs_q[n] <= '0;
      end
    end else if (wb.valid && wb.we && (wb.rd != '0)) begin
      regs_q[wb.rd] <= wb.data;
    end
  end

  // r0 is hardwired
  assign rf.rdata0 = (rf.raddr0 == '0) ? '0 : regs_q[rf.raddr0];
  assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs_q[rf.raddr1];

endmodule : reg_file

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f pipeline.f \
  --top-module tb_pipeline -Mdir obj_dir -o sim_pipeline
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_pipeline
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

echo "simulation finished"
exit 0

// File: tb_pipeline.sv
// =========================================================================
// pipeline top level testbench with directed and random instructions,
// reference register model, retire checker and watchdog
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module tb_pipeline;

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 10;
  localparam int N_RANDOM     = 400;
  // zero reads of every register and two latency probes
  localparam int N_DIRECTED   = pipe_cfg_pkg::REG_NUM + 2;
  localparam int N_TOTAL      = N_RANDOM + N_DIRECTED;
  localparam int TIMEOUT_NS   = N_TOTAL * 4 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  logic                            clk;
  logic                            rst_n_i;
  logic                            inst_valid_i;
  logic [pipe_cfg_pkg::XLEN-1:0]   inst_word_i;
  logic                            inst_ready_o;
  logic                            retire_valid_o;
  logic                            retire_we_o;
  logic [pipe_cfg_pkg::REG_AW-1:0] retire_rd_o;
  logic [pipe_cfg_pkg::XLEN-1:0]   retire_data_o;

  integer seed = 73;

  // reference model state and expected retire stream
  logic [pipe_cfg_pkg::XLEN-1:0]   model_regs [pipe_cfg_pkg::REG_NUM];
  logic                            exp_we_q [$];
  logic [pipe_cfg_pkg::REG_AW-1:0] exp_rd_q [$];
  logic [pipe_cfg_pkg::XLEN-1:0]   exp_data_q [$];
  int                              accepted_cnt;
  int                              retired_cnt;

  pipeline_top u_pipeline_top (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .inst_valid_i   (inst_valid_i),
    .inst_word_i    (inst_word_i),
    .inst_ready_o   (inst_ready_o),
    .retire_valid_o (retire_valid_o),
    .retire_we_o    (retire_we_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ============================ helpers ===================================
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    string line;
    if (got !== exp) begin
      line = $sformatf("MISMATCH time=%0t signal=%s got=0x%08h expected=0x%08h",
                       $time, name, got, exp);
      stop_with_failure(line);
    end
  endtask

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  // mostly r0..r3 so that neighbours depend on each other
  function automatic logic [pipe_cfg_pkg::REG_AW-1:0] pick_reg();
    logic [31:0] r;
    r = rand_word();
    if (r[1:0] != 2'b00) begin
      pick_reg = {3'b000, r[3:2]};
    end else begin
      pick_reg = r[8:4];
    end
  endfunction

  function automatic isa_pkg::inst_u make_random_inst();
    logic [31:0]              r;
    logic [isa_pkg::OP_W-1:0] op;
    isa_pkg::inst_u           w;
    r = rand_word();
    if (r[2:0] == 3'b000) begin
      // any code at all and often one with no meaning
      op = r[7:4];
    end else begin
      case (r[10:8])
        3'd0:    op = isa_pkg::OP_ADD;
        3'd1:    op = isa_pkg::OP_SUB;
        3'd2:    op = isa_pkg::OP_AND;
        3'd3:    op = isa_pkg::OP_OR;
        3'd4:    op = isa_pkg::OP_XOR;
        3'd5:    op = isa_pkg::OP_SLT;
        3'd6:    op = isa_pkg::OP_ADDI;
        default: op = isa_pkg::OP_ORI;
      endcase
    end
    w          = rand_word();
    w.r.opcode = op;
    w.r.rd     = pick_reg();
    w.r.rs1    = pick_reg();
    if ((op == isa_pkg::OP_ADDI) || (op == isa_pkg::OP_ORI)) begin
      r = rand_word();
      if (r[0]) begin
        w.i.imm = r[isa_pkg::IMM_W:1];
      end else begin
        w.i.imm      = '0;
        w.i.imm[3:0] = r[23:20];
      end
    end else begin
      w.r.rs2 = pick_reg();
    end
    return w;
  endfunction

  // executes one accepted word and queues what must retire for it
  task automatic model_accept(input logic [31:0] word);
    isa_pkg::inst_u                w;
    logic [pipe_cfg_pkg::XLEN-1:0] a;
    logic [pipe_cfg_pkg::XLEN-1:0] b;
    logic [pipe_cfg_pkg::XLEN-1:0] imm_ext;
    logic [pipe_cfg_pkg::XLEN-1:0] res;
    logic                          known;
    logic                          we;
    w       = word;
    a       = model_regs[w.i.rs1];
    b       = model_regs[w.r.rs2];
    imm_ext = '0;
    imm_ext[isa_pkg::IMM_W-1:0] = w.i.imm;
    known   = 1'b1;
    res     = '0;
    case (w.r.opcode)
      isa_pkg::OP_ADD:  res = a + b;
      isa_pkg::OP_SUB:  res = a - b;
      isa_pkg::OP_AND:  res = a & b;
      isa_pkg::OP_OR:   res = a | b;
      isa_pkg::OP_XOR:  res = a ^ b;
      isa_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::OP_ADDI: res = a + imm_ext;
      isa_pkg::OP_ORI:  res = a | imm_ext;
      default:          known = 1'b0;
    endcase
    we = known && (w.r.rd != '0);
    if (we) begin
      model_regs[w.r.rd] = res;
    end
    exp_we_q.push_back(we);
    exp_rd_q.push_back(w.r.rd);
    exp_data_q.push_back(res);
    accepted_cnt++;
  endtask

  task automatic drive_inst(input logic valid, input logic [31:0] word);
    @(posedge clk);
    #(DRIVE_DELAY);
    inst_valid_i = valid;
    inst_word_i  = word;
  endtask

  // called with inputs idle and every accepted word already queued
  task automatic wait_drained();
    while (exp_we_q.size() != 0) begin
      @(posedge clk);
    end
    // a few quiet edges catch a duplicated retire
    repeat (4) @(posedge clk);
  endtask

  task automatic measure_latency(input logic [31:0] word);
    int edges;
    drive_inst(1'b1, word);
    // the acceptance edge writes the buffer and is the first one counted
    drive_inst(1'b0, '0);
    edges = 1;
    while (!retire_valid_o && (edges < 8)) begin
      @(posedge clk);
      edges++;
      #(DRIVE_DELAY);
    end
    check_value("retire latency in edges", 32'(edges), 32'd3);
  endtask

  // ======================= monitor and model update =======================
  always @(negedge clk) begin : monitor
    logic                            e_we;
    logic [pipe_cfg_pkg::REG_AW-1:0] e_rd;
    logic [pipe_cfg_pkg::XLEN-1:0]   e_data;
    if (rst_n_i) begin
      // drain keeps pace with one word per cycle
      if (inst_valid_i) begin
        check_value("inst_ready_o", 32'(inst_ready_o), 32'd1);
      end
      if (retire_valid_o) begin
        if (exp_we_q.size() == 0) begin
          stop_with_failure("retire seen with no accepted instruction outstanding");
        end else begin
          e_we   = exp_we_q.pop_front();
          e_rd   = exp_rd_q.pop_front();
          e_data = exp_data_q.pop_front();
          check_value("retire_we_o", 32'(retire_we_o), 32'(e_we));
          check_value("retire_rd_o", 32'(retire_rd_o), 32'(e_rd));
          check_value("retire_data_o", retire_data_o, e_data);
          retired_cnt++;
        end
      end
      if (inst_valid_i && inst_ready_o) begin
        model_accept(inst_word_i);
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    stop_with_failure("timeout: the pipeline did not retire all instructions in time");
  end

  // ============================== stimulus ================================
  initial begin : stimulus
    isa_pkg::inst_u w;
    logic [31:0]    r;
    int             n;
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_word_i  = '0;
    accepted_cnt = 0;
    retired_cnt  = 0;
    for (int k = 0; k < pipe_cfg_pkg::REG_NUM; k++) begin
      model_regs[k] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n_i = 1'b1;
    @(negedge clk);
    check_value("inst_ready_o", 32'(inst_ready_o), 32'd1);
    check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);

    // every register reads zero after reset
    for (int k = 0; k < pipe_cfg_pkg::REG_NUM; k++) begin
      w          = '0;
      w.r.opcode = isa_pkg::OP_ADD;
      w.r.rd     = 5'd1;
      w.r.rs2    = k[pipe_cfg_pkg::REG_AW-1:0];
      drive_inst(1'b1, w);
    end
    drive_inst(1'b0, '0);
    wait_drained();

    // single words into an empty pipeline
    w          = '0;
    w.i.opcode = isa_pkg::OP_ADDI;
    w.i.rd     = 5'd2;
    w.i.imm    = 18'd5;
    measure_latency(w);
    wait_drained();
    w          = '0;
    w.r.opcode = 4'hf;
    w.r.rd     = 5'd3;
    measure_latency(w);
    wait_drained();

    n = 0;
    while (n < N_RANDOM) begin
      r = rand_word();
      if (r[1:0] != 2'b00) begin
        drive_inst(1'b1, make_random_inst());
        n++;
      end else begin
        drive_inst(1'b0, rand_word());
      end
    end
    drive_inst(1'b0, '0);
    wait_drained();

    if ((retired_cnt != accepted_cnt) || (accepted_cnt != N_TOTAL)) begin
      stop_with_failure($sformatf("retired %0d of %0d accepted, %0d were sent",
                                  retired_cnt, accepted_cnt, N_TOTAL));
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule : tb_pipeline

`default_nettype wire
